// File: common/axil_crossbar_cfg.svh
//**************************************************
// Crossbar port counts, slave windows, bank sizes
//**************************************************

`ifndef AXIL_CROSSBAR_CFG_SVH
`define AXIL_CROSSBAR_CFG_SVH

// Port counts
`define AXIL_N_MASTERS 2
`define AXIL_N_SLAVES 2

// Slave windows, matched on the masked address
`define AXIL_SLAVE0_BASE 32'h0000_0000
`define AXIL_SLAVE1_BASE 32'h2000_0000
`define AXIL_SLAVE_MASK 32'hF000_0000

// Register bank sizes
`define AXIL_N_CONTROL_REGS 3
`define AXIL_N_STATUS_REGS 3

`endif

// File: common/axil_pkg.sv
//**************************************************
// AXI-lite bus types, response and arbiter enums,
// request and response channel structs
//**************************************************

package axil_pkg;

    // Bus field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // AXI-lite response codes, EXOKAY is never produced
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axil_resp_e;

    // Per-slave grant FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ
    } arb_state_e;

    // Master toward slave
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axil_req_t;

    // Slave toward master
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_e bresp;
        logic       bvalid;
        data_t      rdata;
        axil_resp_e rresp;
        logic       rvalid;
        logic       arready;
    } axil_rsp_t;

endpackage

// File: crossbar/axil_slave_arbiter.sv
//**************************************************
// Round-robin grant FSM for one crossbar slave port
//**************************************************

`include "axil_crossbar_cfg.svh"

module axil_slave_arbiter (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`AXIL_N_MASTERS-1:0] write_request,
    input  logic [`AXIL_N_MASTERS-1:0] read_request,
    input  logic                       response_done,
    output logic [`AXIL_N_MASTERS-1:0] grant,
    output logic                       grant_write
);

    localparam int N_MASTERS = `AXIL_N_MASTERS;
    localparam int INDEX_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

    axil_pkg::arb_state_e state;
    logic [INDEX_W-1:0]   rr_pointer;
    logic [INDEX_W-1:0]   granted_index;
    logic [INDEX_W-1:0]   next_pointer;
    logic [INDEX_W-1:0]   pick_index;
    logic                 pick_valid;
    logic [N_MASTERS-1:0] any_request;

    assign any_request = write_request | read_request;

    // First requester at or after the pointer; lowest offset is checked last so it wins
    always_comb begin
        int candidate;
        pick_valid = 1'b0;
        pick_index = rr_pointer;
        for (int offset = N_MASTERS - 1; offset >= 0; offset--) begin
            candidate = (int'(rr_pointer) + offset) % N_MASTERS;
            if (any_request[candidate]) begin
                pick_valid = 1'b1;
                pick_index = INDEX_W'(candidate);
            end
        end
    end

    // Priority moves to the master after the one just served
    always_comb begin
        if (int'(granted_index) == N_MASTERS - 1) begin
            next_pointer = '0;
        end else begin
            next_pointer = granted_index + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= axil_pkg::ARB_IDLE;
            rr_pointer <= '0;
            granted_index <= '0;
        end else begin
            case (state)
                axil_pkg::ARB_IDLE: begin
                    if (pick_valid) begin
                        granted_index <= pick_index;
                        if (write_request[pick_index]) begin
                            state <= axil_pkg::ARB_WRITE;
                        end else begin
                            state <= axil_pkg::ARB_READ;
                        end
                    end
                end
                axil_pkg::ARB_WRITE,
                axil_pkg::ARB_READ: begin
                    // Held until the response handshake
                    if (response_done) begin
                        state <= axil_pkg::ARB_IDLE;
                        rr_pointer <= next_pointer;
                    end
                end
                default: state <= axil_pkg::ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        grant = '0;
        if (state != axil_pkg::ARB_IDLE) begin
            grant[granted_index] = 1'b1;
        end
    end

    assign grant_write = (state == axil_pkg::ARB_WRITE);

endmodule

// File: crossbar/axil_crossbar.sv
//**************************************************
// AXI-lite crossbar with window decode, per-slave
// arbitration and a decode-error responder
//**************************************************

`include "axil_crossbar_cfg.svh"

module axil_crossbar (
    input  logic                                        clock,
    input  logic                                        reset,
    input  axil_pkg::axil_req_t [`AXIL_N_MASTERS-1:0] masters_req,
    output axil_pkg::axil_rsp_t [`AXIL_N_MASTERS-1:0] masters_rsp,
    output axil_pkg::axil_req_t [`AXIL_N_SLAVES-1:0]  slaves_req,
    input  axil_pkg::axil_rsp_t [`AXIL_N_SLAVES-1:0]  slaves_rsp
);

    localparam int N_MASTERS = `AXIL_N_MASTERS;
    localparam int N_SLAVES = `AXIL_N_SLAVES;
    localparam axil_pkg::addr_t SLAVE_BASE [N_SLAVES] = '{
        `AXIL_SLAVE0_BASE,
        `AXIL_SLAVE1_BASE
    };

    logic [N_SLAVES-1:0]  aw_match [N_MASTERS];
    logic [N_SLAVES-1:0]  ar_match [N_MASTERS];
    logic [N_MASTERS-1:0] write_valid;
    logic [N_MASTERS-1:0] unmapped_write;
    logic [N_MASTERS-1:0] unmapped_read;

    logic [N_MASTERS-1:0] write_request [N_SLAVES];
    logic [N_MASTERS-1:0] read_request [N_SLAVES];
    logic [N_MASTERS-1:0] grant [N_SLAVES];
    logic [N_SLAVES-1:0]  grant_write;
    logic [N_SLAVES-1:0]  response_done;

    // Decode-error responder state, one set per master
    logic [N_MASTERS-1:0] dec_write_ready;
    logic [N_MASTERS-1:0] dec_read_ready;
    logic [N_MASTERS-1:0] dec_bvalid;
    logic [N_MASTERS-1:0] dec_rvalid;

    // Window decode; a pending write hides the read of the same master
    always_comb begin
        for (int m = 0; m < N_MASTERS; m++) begin
            write_valid[m] = masters_req[m].awvalid & masters_req[m].wvalid;
            for (int s = 0; s < N_SLAVES; s++) begin
                aw_match[m][s] = (masters_req[m].awaddr & `AXIL_SLAVE_MASK) == SLAVE_BASE[s];
                ar_match[m][s] = (masters_req[m].araddr & `AXIL_SLAVE_MASK) == SLAVE_BASE[s];
                write_request[s][m] = write_valid[m] & aw_match[m][s];
                read_request[s][m] = masters_req[m].arvalid & ~write_valid[m]
                                     & ar_match[m][s];
            end
            unmapped_write[m] = write_valid[m] & ~(|aw_match[m]);
            unmapped_read[m] = masters_req[m].arvalid & ~write_valid[m] & ~(|ar_match[m]);
        end
    end

    for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave
        axil_slave_arbiter arbiter (
            .clock(clock),
            .reset(reset),
            .write_request(write_request[s]),
            .read_request(read_request[s]),
            .response_done(response_done[s]),
            .grant(grant[s]),
            .grant_write(grant_write[s])
        );

        assign response_done[s] = (slaves_req[s].bready & slaves_rsp[s].bvalid)
                                | (slaves_req[s].rready & slaves_rsp[s].rvalid);
    end

    // Granted master to slave, only the active direction keeps its valids
    always_comb begin
        for (int s = 0; s < N_SLAVES; s++) begin
            slaves_req[s] = '0;
            for (int m = 0; m < N_MASTERS; m++) begin
                if (grant[s][m]) begin
                    slaves_req[s] = masters_req[m];
                end
            end
            if (grant_write[s]) begin
                slaves_req[s].arvalid = 1'b0;
                slaves_req[s].rready = 1'b0;
            end else begin
                slaves_req[s].awvalid = 1'b0;
                slaves_req[s].wvalid = 1'b0;
                slaves_req[s].bready = 1'b0;
            end
        end
    end

    // Responses steered per channel, decode-error responder when nothing is granted
    always_comb begin
        for (int m = 0; m < N_MASTERS; m++) begin
            masters_rsp[m].awready = dec_write_ready[m];
            masters_rsp[m].wready = dec_write_ready[m];
            masters_rsp[m].bresp = axil_pkg::RESP_DECERR;
            masters_rsp[m].bvalid = dec_bvalid[m];
            masters_rsp[m].arready = dec_read_ready[m];
            masters_rsp[m].rdata = '0;
            masters_rsp[m].rresp = axil_pkg::RESP_DECERR;
            masters_rsp[m].rvalid = dec_rvalid[m];
            for (int s = 0; s < N_SLAVES; s++) begin
                if (grant[s][m] && grant_write[s]) begin
                    masters_rsp[m].awready = slaves_rsp[s].awready;
                    masters_rsp[m].wready = slaves_rsp[s].wready;
                    masters_rsp[m].bresp = slaves_rsp[s].bresp;
                    masters_rsp[m].bvalid = slaves_rsp[s].bvalid;
                end
                if (grant[s][m] && !grant_write[s]) begin
                    masters_rsp[m].arready = slaves_rsp[s].arready;
                    masters_rsp[m].rdata = slaves_rsp[s].rdata;
                    masters_rsp[m].rresp = slaves_rsp[s].rresp;
                    masters_rsp[m].rvalid = slaves_rsp[s].rvalid;
                end
            end
        end
    end

    // Accept one cycle after an unmapped request shows up, respond the cycle after
    always_ff @(posedge clock) begin
        if (reset) begin
            dec_write_ready <= '0;
            dec_read_ready <= '0;
            dec_bvalid <= '0;
            dec_rvalid <= '0;
        end else begin
            for (int m = 0; m < N_MASTERS; m++) begin
                dec_write_ready[m] <= unmapped_write[m] & ~dec_write_ready[m] & ~dec_bvalid[m];
                dec_read_ready[m] <= unmapped_read[m] & ~dec_read_ready[m] & ~dec_rvalid[m];

                if (dec_write_ready[m]) begin
                    dec_bvalid[m] <= 1'b1;
                end else if (masters_req[m].bready) begin
                    dec_bvalid[m] <= 1'b0;
                end

                if (dec_read_ready[m]) begin
                    dec_rvalid[m] <= 1'b1;
                end else if (masters_req[m].rready) begin
                    dec_rvalid[m] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: source/axil_register_bank.sv
//**************************************************
// AXI-lite register slave, strobed control registers
// and read-only status registers
//**************************************************

module axil_register_bank #(
    parameter int N_CONTROL_REGS = 3,
    parameter int N_STATUS_REGS = 3
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  axil_pkg::axil_req_t                      bus_req,
    output axil_pkg::axil_rsp_t                      bus_rsp,
    input  axil_pkg::data_t [N_STATUS_REGS-1:0]      status_in,
    output axil_pkg::data_t [N_CONTROL_REGS-1:0]     control_out
);

    logic [25:0]          write_index;
    logic [25:0]          read_index;
    logic                 write_accept;
    logic                 read_accept;
    logic                 bvalid_q;
    logic                 rvalid_q;
    axil_pkg::axil_resp_e bresp_q;
    axil_pkg::axil_resp_e rresp_q;
    axil_pkg::data_t      rdata_q;

    // Word offset inside the window
    assign write_index = bus_req.awaddr[27:2];
    assign read_index = bus_req.araddr[27:2];

    assign write_accept = bus_req.awvalid & bus_req.wvalid & ~bvalid_q;
    assign read_accept = bus_req.arvalid & ~rvalid_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            control_out <= '0;
        end else begin
            if (write_accept) begin
                bvalid_q <= 1'b1;
                if (write_index < N_CONTROL_REGS) begin
                    for (int b = 0; b < 4; b++) begin
                        if (bus_req.wstrb[b]) begin
                            control_out[write_index][8*b +: 8] <= bus_req.wdata[8*b +: 8];
                        end
                    end
                end
            end else if (bus_req.bready) begin
                bvalid_q <= 1'b0;
            end

            if (read_accept) begin
                rvalid_q <= 1'b1;
            end else if (bus_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Response payload, held stable while the valid waits
    always_ff @(posedge clock) begin
        if (write_accept) begin
            bresp_q <= (write_index < N_CONTROL_REGS) ? axil_pkg::RESP_OKAY
                                                      : axil_pkg::RESP_SLVERR;
        end
        if (read_accept) begin
            if (read_index < N_STATUS_REGS) begin
                rdata_q <= status_in[read_index];
                rresp_q <= axil_pkg::RESP_OKAY;
            end else begin
                rdata_q <= '0;
                rresp_q <= axil_pkg::RESP_SLVERR;
            end
        end
    end

    always_comb begin
        bus_rsp.awready = write_accept;
        bus_rsp.wready = write_accept;
        bus_rsp.bresp = bresp_q;
        bus_rsp.bvalid = bvalid_q;
        bus_rsp.arready = read_accept;
        bus_rsp.rdata = rdata_q;
        bus_rsp.rresp = rresp_q;
        bus_rsp.rvalid = rvalid_q;
    end

endmodule

// File: source/axil_register_subsystem.sv
//**************************************************
// Two-master subsystem, crossbar and two banks
//**************************************************

`include "axil_crossbar_cfg.svh"

module axil_register_subsystem (
    input  logic                                          clock,
    input  logic                                          reset,
    input  axil_pkg::axil_req_t [`AXIL_N_MASTERS-1:0]     masters_req,
    output axil_pkg::axil_rsp_t [`AXIL_N_MASTERS-1:0]     masters_rsp,
    input  axil_pkg::data_t [`AXIL_N_STATUS_REGS-1:0]     bank0_status,
    input  axil_pkg::data_t [`AXIL_N_STATUS_REGS-1:0]     bank1_status,
    output axil_pkg::data_t [`AXIL_N_CONTROL_REGS-1:0]    bank0_control,
    output axil_pkg::data_t [`AXIL_N_CONTROL_REGS-1:0]    bank1_control
);

    axil_pkg::axil_req_t [`AXIL_N_SLAVES-1:0] slaves_req;
    axil_pkg::axil_rsp_t [`AXIL_N_SLAVES-1:0] slaves_rsp;

    axil_crossbar crossbar (
        .clock(clock),
        .reset(reset),
        .masters_req(masters_req),
        .masters_rsp(masters_rsp),
        .slaves_req(slaves_req),
        .slaves_rsp(slaves_rsp)
    );

    // Slave 0 window
    axil_register_bank #(
        .N_CONTROL_REGS(`AXIL_N_CONTROL_REGS),
        .N_STATUS_REGS(`AXIL_N_STATUS_REGS)
    ) bank0 (
        .clock(clock),
        .reset(reset),
        .bus_req(slaves_req[0]),
        .bus_rsp(slaves_rsp[0]),
        .status_in(bank0_status),
        .control_out(bank0_control)
    );

    // Slave 1 window
    axil_register_bank #(
        .N_CONTROL_REGS(`AXIL_N_CONTROL_REGS),
        .N_STATUS_REGS(`AXIL_N_STATUS_REGS)
    ) bank1 (
        .clock(clock),
        .reset(reset),
        .bus_req(slaves_req[1]),
        .bus_rsp(slaves_rsp[1]),
        .status_in(bank1_status),
        .control_out(bank1_control)
    );

endmodule

// File: verification/axil_subsystem_tb.sv
//**************************************************
// Directed testbench for the register subsystem,
// bus tasks, compare tasks, LFSR and test sequence
//**************************************************

`include "axil_crossbar_cfg.svh"

module axil_subsystem_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam logic [31:0] LFSR_SEED = 32'h6b955518;
    localparam int CH_WRITE_ACCEPT = 0;
    localparam int CH_WRITE_RESP = 1;
    localparam int CH_READ_ACCEPT = 2;
    localparam int CH_READ_RESP = 3;

    logic clock;
    logic reset;
    axil_pkg::axil_req_t [`AXIL_N_MASTERS-1:0]  masters_req;
    axil_pkg::axil_rsp_t [`AXIL_N_MASTERS-1:0]  masters_rsp;
    axil_pkg::data_t [`AXIL_N_STATUS_REGS-1:0]  bank0_status;
    axil_pkg::data_t [`AXIL_N_STATUS_REGS-1:0]  bank1_status;
    axil_pkg::data_t [`AXIL_N_CONTROL_REGS-1:0] bank0_control;
    axil_pkg::data_t [`AXIL_N_CONTROL_REGS-1:0] bank1_control;

    // Expected control register contents, per bank
    axil_pkg::data_t shadow [2][`AXIL_N_CONTROL_REGS];
    logic [31:0] lfsr_state;
    string current_test;
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    axil_register_subsystem UUT (
        .clock(clock),
        .reset(reset),
        .masters_req(masters_req),
        .masters_rsp(masters_rsp),
        .bank0_status(bank0_status),
        .bank1_status(bank1_status),
        .bank0_control(bank0_control),
        .bank1_control(bank1_control)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic take_random(input int nbits, output axil_pkg::data_t value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic axil_pkg::addr_t reg_addr(input int bank, input int index);
        axil_pkg::addr_t base;
        base = (bank == 0) ? `AXIL_SLAVE0_BASE : `AXIL_SLAVE1_BASE;
        return base + axil_pkg::addr_t'(index * 4);
    endfunction

    function automatic axil_pkg::data_t control_value(input int bank, input int index);
        return (bank == 0) ? bank0_control[index] : bank1_control[index];
    endfunction

    function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_value,
                                                     input axil_pkg::data_t new_value,
                                                     input axil_pkg::strb_t strb);
        axil_pkg::data_t merged;
        merged = old_value;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_value[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_data(input string what, input axil_pkg::data_t expected,
                              input axil_pkg::data_t actual);
        if (actual !== expected) begin
            $display("error %s (%s): expected %h, actual %h", current_test, what, expected,
                     actual);
            test_errors++;
        end
    endtask

    task automatic check_resp(input string what, input axil_pkg::axil_resp_e expected,
                              input axil_pkg::axil_resp_e actual);
        if (actual !== expected) begin
            $display("error %s (%s): expected resp %0d, actual resp %0d", current_test, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_control(input string what, input axil_pkg::data_t expected,
                                 input axil_pkg::data_t actual);
        if (actual !== expected) begin
            $display("error %s (%s): expected %h, actual %h", current_test, what, expected,
                     actual);
            test_errors++;
        end
    endtask

    task automatic check_all_controls();
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < `AXIL_N_CONTROL_REGS; i++) begin
                check_control($sformatf("bank%0d control %0d", b, i), shadow[b][i],
                              control_value(b, i));
            end
        end
    endtask

    task automatic drive_req(input int m, input axil_pkg::axil_req_t value);
        if (m == 0) begin
            masters_req[0] <= value;
        end else begin
            masters_req[1] <= value;
        end
    endtask

    function automatic bit channel_flag(input int m, input int kind);
        case (kind)
            CH_WRITE_ACCEPT: return masters_rsp[m].awready & masters_rsp[m].wready;
            CH_WRITE_RESP:   return masters_rsp[m].bvalid;
            CH_READ_ACCEPT:  return masters_rsp[m].arready;
            default:         return masters_rsp[m].rvalid;
        endcase
    endfunction

    // Flags are sampled at the clock edge, before this edge's updates land
    task automatic wait_for_channel(input int m, input int kind, input string what,
                                    output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
            seen = channel_flag(m, kind);
        end
        if (!seen) begin
            $display("%s: master %0d saw no %s within %0d cycles", current_test, m, what,
                     TIMEOUT_CYCLES);
            test_errors++;
        end
    endtask

    // hold_cycles keeps bready low that long once bvalid is up
    task automatic axil_write(input int m, input axil_pkg::addr_t addr,
                              input axil_pkg::data_t data, input axil_pkg::strb_t strb,
                              input int hold_cycles, output axil_pkg::axil_resp_e resp,
                              output time done_time);
        axil_pkg::axil_req_t req;
        bit seen;
        req = '0;
        req.awaddr = addr;
        req.wdata = data;
        req.wstrb = strb;
        req.awvalid = 1'b1;
        req.wvalid = 1'b1;
        req.bready = (hold_cycles == 0);
        resp = axil_pkg::RESP_OKAY;
        done_time = 0;
        @(posedge clock);
        drive_req(m, req);
        wait_for_channel(m, CH_WRITE_ACCEPT, "write address and data ready", seen);
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        drive_req(m, req);
        if (seen && hold_cycles > 0) begin
            wait_for_channel(m, CH_WRITE_RESP, "write response", seen);
            for (int i = 0; i < hold_cycles && seen; i++) begin
                @(posedge clock);
                if (!masters_rsp[m].bvalid) begin
                    $display("%s: bvalid dropped while bready was held low", current_test);
                    test_errors++;
                end
            end
            req.bready = 1'b1;
            drive_req(m, req);
        end
        if (seen) begin
            wait_for_channel(m, CH_WRITE_RESP, "write response", seen);
            resp = masters_rsp[m].bresp;
            done_time = $time;
        end
        req.bready = 1'b0;
        drive_req(m, req);
    endtask

    task automatic axil_read(input int m, input axil_pkg::addr_t addr,
                             output axil_pkg::data_t data, output axil_pkg::axil_resp_e resp);
        axil_pkg::axil_req_t req;
        bit seen;
        req = '0;
        req.araddr = addr;
        req.arvalid = 1'b1;
        req.rready = 1'b1;
        data = '0;
        resp = axil_pkg::RESP_OKAY;
        @(posedge clock);
        drive_req(m, req);
        wait_for_channel(m, CH_READ_ACCEPT, "read address ready", seen);
        req.arvalid = 1'b0;
        drive_req(m, req);
        if (seen) begin
            wait_for_channel(m, CH_READ_RESP, "read data", seen);
            data = masters_rsp[m].rdata;
            resp = masters_rsp[m].rresp;
        end
        req.rready = 1'b0;
        drive_req(m, req);
    endtask

    task automatic reset_dut();
        @(posedge clock);
        reset <= 1'b1;
        masters_req <= '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < `AXIL_N_CONTROL_REGS; i++) begin
                shadow[b][i] = '0;
            end
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", current_test, test_errors);
        end
    endtask

    task automatic test_routing();
        axil_pkg::data_t value;
        axil_pkg::data_t data;
        axil_pkg::data_t [`AXIL_N_STATUS_REGS-1:0] s0;
        axil_pkg::data_t [`AXIL_N_STATUS_REGS-1:0] s1;
        axil_pkg::axil_resp_e resp;
        time t;
        start_test("routing");
        for (int m = 0; m < 2; m++) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `AXIL_N_CONTROL_REGS; i++) begin
                    take_random(32, value);
                    axil_write(m, reg_addr(b, i), value, 4'hF, 0, resp, t);
                    check_resp("write resp", axil_pkg::RESP_OKAY, resp);
                    shadow[b][i] = value;
                    check_control("control after write", shadow[b][i], control_value(b, i));
                end
            end
        end
        for (int m = 0; m < 2; m++) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `AXIL_N_STATUS_REGS; i++) begin
                    for (int k = 0; k < `AXIL_N_STATUS_REGS; k++) begin
                        take_random(32, s0[k]);
                        take_random(32, s1[k]);
                    end
                    @(posedge clock);
                    bank0_status <= s0;
                    bank1_status <= s1;
                    axil_read(m, reg_addr(b, i), data, resp);
                    check_data("status read", (b == 0) ? s0[i] : s1[i], data);
                    check_resp("read resp", axil_pkg::RESP_OKAY, resp);
                end
            end
        end
        finish_test();
    endtask

    task automatic test_byte_strobes();
        axil_pkg::data_t value;
        axil_pkg::data_t pick;
        axil_pkg::strb_t strb;
        axil_pkg::axil_resp_e resp;
        int m;
        int b;
        int i;
        time t;
        start_test("byte_strobes");
        for (int k = 0; k < 8; k++) begin
            take_random(1, pick);
            m = int'(pick);
            take_random(1, pick);
            b = int'(pick);
            take_random(2, pick);
            i = int'(pick % 3);
            take_random(4, pick);
            // Single bytes first, then random patterns
            strb = (k < 4) ? axil_pkg::strb_t'(1 << k) : pick[3:0];
            take_random(32, value);
            axil_write(m, reg_addr(b, i), value, strb, 0, resp, t);
            check_resp("write resp", axil_pkg::RESP_OKAY, resp);
            shadow[b][i] = merge_bytes(shadow[b][i], value, strb);
            check_all_controls();
        end
        finish_test();
    endtask

    task automatic test_out_of_range();
        axil_pkg::data_t value;
        axil_pkg::data_t data;
        axil_pkg::axil_resp_e resp;
        time t;
        start_test("out_of_range");
        for (int b = 0; b < 2; b++) begin
            take_random(32, value);
            axil_write(b, reg_addr(b, 3), value, 4'hF, 0, resp, t);
            check_resp("write resp", axil_pkg::RESP_SLVERR, resp);
            check_all_controls();
            axil_read(1 - b, reg_addr(b, 3), data, resp);
            check_resp("read resp", axil_pkg::RESP_SLVERR, resp);
            check_data("read data", '0, data);
        end
        finish_test();
    endtask

    task automatic test_unmapped();
        axil_pkg::addr_t addrs [2];
        axil_pkg::data_t value;
        axil_pkg::data_t data;
        axil_pkg::axil_resp_e resp;
        time t;
        addrs[0] = 32'h4000_0000;
        addrs[1] = 32'hF000_0004;
        start_test("unmapped");
        for (int a = 0; a < 2; a++) begin
            for (int m = 0; m < 2; m++) begin
                take_random(32, value);
                axil_write(m, addrs[a], value, 4'hF, 0, resp, t);
                check_resp("write resp", axil_pkg::RESP_DECERR, resp);
                axil_read(m, addrs[a], data, resp);
                check_resp("read resp", axil_pkg::RESP_DECERR, resp);
                check_data("read data", '0, data);
            end
        end
        check_all_controls();
        finish_test();
    endtask

    // Same register from both masters in one cycle, master 0 has priority after reset
    task automatic test_contention();
        axil_pkg::data_t d0;
        axil_pkg::data_t d1;
        axil_pkg::axil_resp_e r0;
        axil_pkg::axil_resp_e r1;
        time t0;
        time t1;
        start_test("contention");
        reset_dut();
        take_random(32, d0);
        take_random(32, d1);
        fork
            axil_write(0, reg_addr(0, 1), d0, 4'hF, 0, r0, t0);
            axil_write(1, reg_addr(0, 1), d1, 4'hF, 0, r1, t1);
        join
        check_resp("master 0 resp", axil_pkg::RESP_OKAY, r0);
        check_resp("master 1 resp", axil_pkg::RESP_OKAY, r1);
        if (t1 <= t0) begin
            $display("%s: master 1 finished before master 0", current_test);
            test_errors++;
        end
        shadow[0][1] = d1;
        check_all_controls();
        finish_test();
    endtask

    task automatic test_back_pressure();
        axil_pkg::data_t d0;
        axil_pkg::data_t d1;
        axil_pkg::axil_resp_e r0;
        axil_pkg::axil_resp_e r1;
        time t0;
        time t1;
        start_test("back_pressure");
        take_random(32, d0);
        take_random(32, d1);
        fork
            axil_write(0, reg_addr(0, 0), d0, 4'hF, 20, r0, t0);
            begin
                repeat (3) @(posedge clock);
                axil_write(1, reg_addr(0, 2), d1, 4'hF, 0, r1, t1);
            end
        join
        check_resp("master 0 resp", axil_pkg::RESP_OKAY, r0);
        check_resp("master 1 resp", axil_pkg::RESP_OKAY, r1);
        if (t1 <= t0) begin
            $display("%s: master 1 completed before the held response of master 0",
                     current_test);
            test_errors++;
        end
        shadow[0][0] = d0;
        shadow[0][2] = d1;
        check_all_controls();
        finish_test();
    endtask

    initial begin
        reset = 1'b1;
        masters_req = '0;
        bank0_status = '0;
        bank1_status = '0;
        lfsr_state = LFSR_SEED;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        reset_dut();
        test_routing();
        test_byte_strobes();
        test_out_of_range();
        test_unmapped();
        test_contention();
        test_back_pressure();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+common
common/axil_pkg.sv
crossbar/axil_slave_arbiter.sv
crossbar/axil_crossbar.sv
source/axil_register_bank.sv
source/axil_register_subsystem.sv
verification/axil_subsystem_tb.sv
